// ==== Bender.yml ====
package:
  name: little_computer

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/little_computer_pkg.sv
      - source/mem_port_if.sv
      - source/uart_rx.sv
      - source/uart_word_assembler.sv
      - source/load_sequencer.sv
      - source/program_ram.sv
      - source/hex_seg_display.sv
      - source/little_computer.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/little_computer_assertions.sv
      - tb/tb_little_computer.sv

// ==== include/little_computer_defines.svh ====
`ifndef LITTLE_COMPUTER_DEFINES_SVH
`define LITTLE_COMPUTER_DEFINES_SVH

// memory word and address widths
`define WORD_WIDTH 16
`define ADDR_WIDTH 8

// sysclk cycles for one serial bit
`define CLKS_PER_BIT 16

`endif

// ==== source/hex_seg_display.sv ====
`timescale 1ns/100ps

module hex_seg_display (
    input  logic        debug_en,
    input  logic [23:0] value,
    output logic [47:0] hex
);

    // active low, bit order gfedcba
    function automatic logic [6:0] seg_pattern(input logic [3:0] nibble);
        case (nibble)
            4'h0:    return 7'h40;
            4'h1:    return 7'h79;
            4'h2:    return 7'h24;
            4'h3:    return 7'h30;
            4'h4:    return 7'h19;
            4'h5:    return 7'h12;
            4'h6:    return 7'h02;
            4'h7:    return 7'h78;
            4'h8:    return 7'h00;
            4'h9:    return 7'h10;
            4'hA:    return 7'h08;
            4'hB:    return 7'h03;
            4'hC:    return 7'h46;
            4'hD:    return 7'h21;
            4'hE:    return 7'h06;
            4'hF:    return 7'h0E;
            default: return 7'h7F;
        endcase
    endfunction

    // digit 0 is the lowest nibble, decimal point stays dark
    always_comb begin
        for (int i = 0; i < 6; i++) begin
            if (debug_en) begin
                hex[i*8 +: 8] = {1'b1, seg_pattern(value[i*4 +: 4])};
            end else begin
                hex[i*8 +: 8] = 8'hFF;
            end
        end
    end

endmodule

// ==== source/little_computer.sv ====
`timescale 1ns/100ps

module little_computer (
    input  logic       sysclk,
    input  logic       sysrst,
    input  logic       rx,
    input  logic       load_en,
    input  logic       debug_en,
    input  logic [7:0] peek_addr,
    output logic [7:0] hex0,
    output logic [7:0] hex1,
    output logic [7:0] hex2,
    output logic [7:0] hex3,
    output logic [7:0] hex4,
    output logic [7:0] hex5,
    output logic [9:0] led
);
    import little_computer_pkg::*;

    byte_t rx_byte;
    logic  byte_ready;
    word_t rx_word;
    logic  word_ready;
    logic  phase_clear;
    logic  running;
    addr_t word_count;
    word_t peek_data;
    addr_t peek_addr_q;
    logic  led_load_meta;
    logic  led_load_sync;

    mem_port_if mem_bus ();

    uart_rx u_uart_rx (
        .sysclk     (sysclk),
        .sysrst     (sysrst),
        .rx         (rx),
        .byte_data  (rx_byte),
        .byte_ready (byte_ready)
    );

    uart_word_assembler u_word_asm (
        .sysclk      (sysclk),
        .sysrst      (sysrst),
        .byte_data   (rx_byte),
        .byte_ready  (byte_ready),
        .phase_clear (phase_clear),
        .word_data   (rx_word),
        .word_ready  (word_ready)
    );

    load_sequencer u_load_seq (
        .sysclk      (sysclk),
        .sysrst      (sysrst),
        .load_en     (load_en),
        .word_data   (rx_word),
        .word_ready  (word_ready),
        .phase_clear (phase_clear),
        .running     (running),
        .word_count  (word_count),
        .mem         (mem_bus.writer)
    );

    program_ram u_program_ram (
        .sysclk      (sysclk),
        .sysrst      (sysrst),
        .peek_addr   (peek_addr),
        .peek_data   (peek_data),
        .peek_addr_q (peek_addr_q),
        .mem         (mem_bus.memory)
    );

    // word on the upper four digits, address on the lower two
    hex_seg_display u_hex (
        .debug_en (debug_en),
        .value    ({peek_data, peek_addr_q}),
        .hex      ({hex5, hex4, hex3, hex2, hex1, hex0})
    );

    // switch state for the led only
    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            led_load_meta <= 1'b0;
            led_load_sync <= 1'b0;
        end else begin
            led_load_meta <= load_en;
            led_load_sync <= led_load_meta;
        end
    end

    assign led = {running, led_load_sync, word_count};

endmodule

// ==== source/little_computer_pkg.sv ====
`include "little_computer_defines.svh"

package little_computer_pkg;

    // one serial payload byte
    typedef logic [7:0] byte_t;

    // program memory word and address
    typedef logic [`WORD_WIDTH-1:0] word_t;
    typedef logic [`ADDR_WIDTH-1:0] addr_t;

    // loader run state, held in reset until memory clear is done
    typedef enum logic {
        LOAD_RESET   = 1'b0,
        LOAD_RUNNING = 1'b1
    } load_state_e;

endpackage

// ==== source/load_sequencer.sv ====
`timescale 1ns/100ps

module load_sequencer (
    input  logic                       sysclk,
    input  logic                       sysrst,
    input  logic                       load_en,
    input  little_computer_pkg::word_t word_data,
    input  logic                       word_ready,
    output logic                       phase_clear,
    output logic                       running,
    output little_computer_pkg::addr_t word_count,
    mem_port_if.writer                 mem
);
    import little_computer_pkg::*;

    load_state_e state;
    logic        load_meta;
    logic        load_sync;
    logic        load_prev;
    logic        load_rise;
    logic        accept;

    assign load_rise = load_sync && !load_prev;
    assign running   = (state == LOAD_RUNNING);

    // an edge of the switch wins over a word in the same cycle
    assign accept = word_ready && running && load_sync && !load_rise;

    // hold the loader until the memory clear is done
    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            state <= LOAD_RESET;
        end else if (state == LOAD_RESET && mem.ready) begin
            state <= LOAD_RUNNING;
        end
    end

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            load_meta    <= 1'b0;
            load_sync    <= 1'b0;
            load_prev    <= 1'b0;
            phase_clear  <= 1'b0;
            word_count   <= '0;
            mem.write_en <= 1'b0;
        end else begin
            load_meta    <= load_en;
            load_sync    <= load_meta;
            load_prev    <= load_sync;
            phase_clear  <= load_rise;
            mem.write_en <= accept;
            if (load_rise) begin
                word_count <= '0;
            end else if (accept) begin
                word_count <= word_count + 1'b1;
            end
        end
    end

    // write address is the count before the increment
    always_ff @(posedge sysclk) begin
        if (accept) begin
            mem.addr  <= word_count;
            mem.wdata <= word_data;
        end
    end

endmodule

// ==== source/mem_port_if.sv ====
`timescale 1ns/100ps

interface mem_port_if;
    import little_computer_pkg::*;

    logic  write_en;
    addr_t addr;
    word_t wdata;
    // high once the memory has finished clearing
    logic  ready;

    modport writer (
        output write_en,
        output addr,
        output wdata,
        input  ready
    );

    modport memory (
        input  write_en,
        input  addr,
        input  wdata,
        output ready
    );

endinterface

// ==== source/program_ram.sv ====
`timescale 1ns/100ps
`include "little_computer_defines.svh"

module program_ram (
    input  logic                       sysclk,
    input  logic                       sysrst,
    input  little_computer_pkg::addr_t peek_addr,
    output little_computer_pkg::word_t peek_data,
    output little_computer_pkg::addr_t peek_addr_q,
    mem_port_if.memory                 mem
);
    import little_computer_pkg::*;

    localparam int DEPTH = 1 << `ADDR_WIDTH;

    word_t ram [DEPTH];
    addr_t clear_addr;
    logic  cleared;

    assign mem.ready = cleared;

    // one clear write per cycle, ready follows the last one
    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            clear_addr <= '0;
            cleared    <= 1'b0;
        end else if (!cleared) begin
            clear_addr <= clear_addr + 1'b1;
            if (clear_addr == addr_t'(DEPTH - 1)) begin
                cleared <= 1'b1;
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (!cleared) begin
            ram[clear_addr] <= '0;
        end else if (mem.write_en) begin
            ram[mem.addr] <= mem.wdata;
        end
    end

    // inspection port, address comes back with its data
    always_ff @(posedge sysclk) begin
        peek_data   <= ram[peek_addr];
        peek_addr_q <= peek_addr;
    end

endmodule

// ==== source/uart_rx.sv ====
`timescale 1ns/100ps
`include "little_computer_defines.svh"

module uart_rx (
    input  logic                       sysclk,
    input  logic                       sysrst,
    input  logic                       rx,
    output little_computer_pkg::byte_t byte_data,
    output logic                       byte_ready
);
    import little_computer_pkg::*;

    localparam int TIMER_W = $clog2(`CLKS_PER_BIT);
    localparam logic [TIMER_W-1:0] HALF_BIT = TIMER_W'(`CLKS_PER_BIT / 2 - 1);
    localparam logic [TIMER_W-1:0] FULL_BIT = TIMER_W'(`CLKS_PER_BIT - 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e          state;
    logic               rx_meta;
    logic               rx_sync;
    logic               rx_prev;
    logic [TIMER_W-1:0] bit_timer;
    logic [2:0]         bit_idx;
    byte_t              shift_reg;

    // line idles high
    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            state      <= RX_IDLE;
            bit_timer  <= '0;
            bit_idx    <= '0;
            byte_ready <= 1'b0;
        end else begin
            byte_ready <= 1'b0;
            case (state)
                RX_IDLE: begin
                    bit_timer <= '0;
                    if (rx_prev && !rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // start bit must still be low at its middle
                    if (bit_timer == HALF_BIT) begin
                        bit_timer <= '0;
                        bit_idx   <= '0;
                        state     <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        bit_timer <= bit_timer + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_timer == FULL_BIT) begin
                        bit_timer <= '0;
                        bit_idx   <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        bit_timer <= bit_timer + 1'b1;
                    end
                end
                RX_STOP: begin
                    // a low stop bit drops the byte
                    if (bit_timer == FULL_BIT) begin
                        state      <= RX_IDLE;
                        byte_ready <= rx_sync;
                    end else begin
                        bit_timer <= bit_timer + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge sysclk) begin
        if (state == RX_DATA && bit_timer == FULL_BIT) begin
            shift_reg <= {rx_sync, shift_reg[7:1]};
        end
        if (state == RX_STOP && bit_timer == FULL_BIT) begin
            byte_data <= shift_reg;
        end
    end

endmodule

// ==== source/uart_word_assembler.sv ====
`timescale 1ns/100ps

module uart_word_assembler (
    input  logic                       sysclk,
    input  logic                       sysrst,
    input  little_computer_pkg::byte_t byte_data,
    input  logic                       byte_ready,
    input  logic                       phase_clear,
    output little_computer_pkg::word_t word_data,
    output logic                       word_ready
);
    import little_computer_pkg::*;

    byte_t high_byte;
    logic  low_phase;
    logic  take_low;

    // phase_clear turns a pending low byte back into a high byte
    assign take_low = low_phase && !phase_clear;

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            low_phase  <= 1'b0;
            word_ready <= 1'b0;
        end else begin
            word_ready <= byte_ready && take_low;
            if (byte_ready) begin
                low_phase <= !take_low;
            end else if (phase_clear) begin
                low_phase <= 1'b0;
            end
        end
    end

    // big endian, first byte is the high byte
    always_ff @(posedge sysclk) begin
        if (byte_ready && !take_low) begin
            high_byte <= byte_data;
        end
        if (byte_ready && take_low) begin
            word_data <= {high_byte, byte_data};
        end
    end

endmodule

// ==== tb.f ====
+incdir+include
source/little_computer_pkg.sv
source/mem_port_if.sv
source/uart_rx.sv
source/uart_word_assembler.sv
source/load_sequencer.sv
source/program_ram.sv
source/hex_seg_display.sv
source/little_computer.sv
tb/little_computer_assertions.sv
tb/tb_little_computer.sv

// ==== tb/little_computer_assertions.sv ====
`timescale 1ns/100ps

module little_computer_assertions (
    input logic sysclk,
    input logic sysrst,
    input logic write_en,
    input logic ready
);

    // a write during the clear would be lost
    write_only_when_ready: assert property (
        @(posedge sysclk) disable iff (!sysrst) write_en |-> ready
    ) else $error("write_en high while the memory is still clearing");

    // each accepted word gives a single pulse
    write_is_one_cycle: assert property (
        @(posedge sysclk) disable iff (!sysrst) write_en |=> !write_en
    ) else $error("write_en high on two consecutive cycles");

    // ready holds until the next reset
    ready_stays_high: assert property (
        @(posedge sysclk) disable iff (!sysrst) ready |=> ready
    ) else $error("ready dropped without a reset");

endmodule

// ==== tb/tb_little_computer.sv ====
`timescale 1ns/100ps
`include "little_computer_defines.svh"

module tb_little_computer;
    import little_computer_pkg::*;

    localparam int TOTAL_FRAMES = 40 + 10 + 3 + 3;
    localparam longint WATCHDOG_NS = longint'(TOTAL_FRAMES) * 10 * `CLKS_PER_BIT * 20 + 20000;
    // active low gfedcba, decimal point dark
    localparam logic [7:0] SEG_TABLE [16] = '{
        8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
        8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E
    };

    logic       sysclk;
    logic       sysrst;
    logic       rx;
    logic       load_en;
    logic       debug_en;
    logic [7:0] peek_addr;
    logic [7:0] hex0;
    logic [7:0] hex1;
    logic [7:0] hex2;
    logic [7:0] hex3;
    logic [7:0] hex4;
    logic [7:0] hex5;
    logic [9:0] led;
    word_t      expected_mem [256];
    addr_t      expected_count;

    little_computer uut (.*);

    bind load_sequencer little_computer_assertions u_assertions (
        .sysclk   (sysclk),
        .sysrst   (sysrst),
        .write_en (mem.write_en),
        .ready    (mem.ready)
    );

    always #10 sysclk = ~sysclk;

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            stop_run($sformatf("error at %0t ns: %s is %h, expected %h",
                               $time, name, actual, expected));
        end
    endtask

    task automatic check_addr(input string name, input addr_t actual, input addr_t expected);
        if (actual !== expected) begin
            stop_run($sformatf("error at %0t ns: %s is %h, expected %h",
                               $time, name, actual, expected));
        end
    endtask

    task automatic check_hex(input string name, input logic [7:0] actual,
                             input logic [7:0] expected);
        if (actual !== expected) begin
            stop_run($sformatf("error at %0t ns: %s is %h, expected %h",
                               $time, name, actual, expected));
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            stop_run($sformatf("error at %0t ns: %s is %b, expected %b",
                               $time, name, actual, expected));
        end
    endtask

    // unknown pattern decodes to x
    function automatic logic [3:0] decode_digit(input logic [7:0] seg);
        logic [3:0] nibble;
        nibble = 4'bx;
        for (int i = 0; i < 16; i++) begin
            if (seg === SEG_TABLE[i]) nibble = 4'(i);
        end
        return nibble;
    endfunction

    // start bit, data lsb first, stop bit
    task automatic send_byte(input byte_t data, input logic stop_bit);
        logic [9:0] frame;
        frame = {stop_bit, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge sysclk);
            #2 rx = frame[i];
            repeat (`CLKS_PER_BIT - 1) @(posedge sysclk);
        end
        // line must go idle again before the next start edge
        if (!stop_bit) begin
            @(posedge sysclk);
            #2 rx = 1'b1;
            repeat (`CLKS_PER_BIT - 1) @(posedge sysclk);
        end
    endtask

    task automatic wait_for_count();
        repeat (4 * `CLKS_PER_BIT) begin
            @(negedge sysclk);
            if (led[7:0] === expected_count) break;
        end
        check_addr("word count led[7:0]", led[7:0], expected_count);
    endtask

    task automatic store_word(input word_t value);
        send_byte(value[15:8], 1'b1);
        send_byte(value[7:0], 1'b1);
        expected_mem[expected_count] = value;
        expected_count++;
        wait_for_count();
    endtask

    task automatic set_load_mode(input logic on);
        @(posedge sysclk);
        #2 load_en = on;
        // two sync stages and the edge detector
        repeat (4) @(posedge sysclk);
        @(negedge sysclk);
        check_bit("load mode led[8]", led[8], on);
        if (on) expected_count = '0;
    endtask

    task automatic check_peek(input addr_t addr);
        logic [47:0] digits;
        word_t       shown_word;
        addr_t       shown_addr;
        digits = {hex5, hex4, hex3, hex2, hex1, hex0};
        for (int i = 0; i < 2; i++) shown_addr[i*4 +: 4] = decode_digit(digits[i*8 +: 8]);
        for (int i = 0; i < 4; i++) shown_word[i*4 +: 4] = decode_digit(digits[i*8+16 +: 8]);
        check_addr("displayed address", shown_addr, addr);
        check_word($sformatf("displayed word at %h", addr), shown_word, expected_mem[addr]);
    endtask

    // one address per cycle, digits lag the address by one edge
    task automatic verify_range(input int first, input int last);
        for (int a = first; a <= last + 1; a++) begin
            @(posedge sysclk);
            #2;
            if (a <= last) peek_addr = addr_t'(a);
            @(negedge sysclk);
            if (a > first) check_peek(addr_t'(a - 1));
        end
    endtask

    task automatic test_clear_and_start();
        int cycles;
        cycles = 0;
        while (led[9] !== 1'b1) begin
            @(negedge sysclk);
            cycles++;
            if (cycles > 300) stop_run("running LED did not rise within 300 cycles of reset");
        end
        wait_for_count();
        verify_range(0, 255);
    endtask

    task automatic test_load();
        set_load_mode(1'b1);
        repeat (20) store_word(word_t'($urandom));
        verify_range(0, 20);
    endtask

    task automatic test_restart();
        set_load_mode(1'b0);
        set_load_mode(1'b1);
        wait_for_count();
        repeat (5) store_word(word_t'($urandom));
        verify_range(0, 20);
    endtask

    // odd byte count leaves a high byte pending for the next restart
    task automatic test_load_off();
        set_load_mode(1'b0);
        repeat (3) send_byte(byte_t'($urandom), 1'b1);
        repeat (`CLKS_PER_BIT) @(posedge sysclk);
        wait_for_count();
        verify_range(0, 20);
    endtask

    task automatic test_framing_error();
        byte_t high_byte;
        byte_t low_byte;
        high_byte = byte_t'($urandom);
        low_byte  = byte_t'($urandom);
        set_load_mode(1'b1);
        send_byte(8'hA5, 1'b0);
        send_byte(high_byte, 1'b1);
        send_byte(low_byte, 1'b1);
        expected_mem[0] = {high_byte, low_byte};
        expected_count  = 8'd1;
        wait_for_count();
        repeat (`CLKS_PER_BIT) @(posedge sysclk);
        wait_for_count();
        verify_range(0, 20);
    endtask

    task automatic test_display_off();
        logic [47:0] digits;
        @(posedge sysclk);
        #2 debug_en = 1'b0;
        @(negedge sysclk);
        digits = {hex5, hex4, hex3, hex2, hex1, hex0};
        for (int i = 0; i < 6; i++) check_hex($sformatf("hex%0d", i), digits[i*8 +: 8], 8'hFF);
    endtask

    initial begin
        #(WATCHDOG_NS);
        stop_run("run timed out before all tests finished");
    end

    initial begin
        sysclk    = 1'b0;
        sysrst    = 1'b0;
        rx        = 1'b1;
        load_en   = 1'b0;
        debug_en  = 1'b1;
        peek_addr = '0;
        void'($urandom(32'h3517));
        foreach (expected_mem[i]) expected_mem[i] = '0;
        expected_count = '0;
        repeat (16) @(posedge sysclk);
        #2 sysrst = 1'b1;
        test_clear_and_start();
        test_load();
        test_restart();
        test_load_off();
        test_framing_error();
        test_display_off();
        $display("STATUS: PASS");
        $finish;
    end

endmodule
